/* hw/pci_bus_pkg.sv */
package pci_bus_pkg;

  //////////////////////////////////////////////////
  // Bus widths

  localparam int ADDR_W = 32;                         // AD and RAM word width
  localparam int BE_W   = 4;                          // C_BE and RAM byte enable width

  localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(4); // One 32-bit word per data phase

  localparam logic [1:0] BURST_LINEAR = 2'b00;        // Low AD bits in address phase

  //////////////////////////////////////////////////
  // Bus commands on C_BE in the address phase

  typedef enum logic [BE_W-1:0] {
    INT_ACK       = 4'b0000,                          // Never claimed
    MEM_READ      = 4'b0110,                          // Short read
    MEM_WRITE     = 4'b0111,
    MEM_READ_MULT = 4'b1100,                          // Open-ended read
    DUAL_ADDR     = 4'b1101,                          // Never claimed
    MEM_READ_LINE = 4'b1110                           // Cache line read
  } pci_cmd_e;

endpackage

/* hw/pci_target_pkg.sv */
package pci_target_pkg;

  //////////////////////////////////////////////////
  // Transaction states

  typedef enum logic [2:0] {
    idle        = 3'd0,                               // Bus free
    decode      = 3'd1,                               // Address phase captured
    claim       = 3'd2,                               // RAM hit check
    wr_data     = 3'd3,                               // Write data phases
    turn_around = 3'd4,                               // AD ownership swap
    r_data      = 3'd5,                               // Read data phases
    disconnect  = 3'd6,                               // STOP until FRAME rises
    terminate   = 3'd7                                // Release everything
  } target_state_e;

  //////////////////////////////////////////////////
  // Read word budgets

  localparam int BUDGET_W = 3;

  localparam logic [BUDGET_W-1:0] READ_BUDGET = 3'd2; // Memory Read
  localparam logic [BUDGET_W-1:0] LINE_BUDGET = 3'd4; // Memory Read Line

endpackage

/* hw/pci_cmd_decode.sv */
module pci_cmd_decode (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic [pci_bus_pkg::ADDR_W-1:0]    ad_in,
  input  logic [pci_bus_pkg::BE_W-1:0]      c_be,
  input  logic                              frame_n,
  input  pci_target_pkg::target_state_e     state,
  output pci_bus_pkg::pci_cmd_e             cmd,
  output logic [pci_bus_pkg::ADDR_W-1:0]    base_addr,
  output logic                              cmd_ok,
  output logic                              burst_ok
);
  import pci_bus_pkg::*;
  import pci_target_pkg::*;

  logic addr_phase;                                   // First FRAME edge while idle
  logic mem_cmd;                                      // Command is one we can serve

  assign addr_phase = (state == idle) && !frame_n;

  always_comb
  begin
    case (c_be)
      MEM_READ, MEM_WRITE, MEM_READ_MULT, MEM_READ_LINE:
        mem_cmd = 1'b1;
      INT_ACK, DUAL_ADDR:
        mem_cmd = 1'b0;                               // Left for another agent
      default:
        mem_cmd = 1'b0;                               // Reserved and I/O codes
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cmd      <= INT_ACK;
      cmd_ok   <= 1'b0;
      burst_ok <= 1'b0;
    end
    else if (addr_phase)
    begin
      cmd      <= pci_cmd_e'(c_be);                   // Held for the whole transaction
      cmd_ok   <= mem_cmd;
      burst_ok <= (ad_in[1:0] == BURST_LINEAR);       // Only linear order is served
    end
  end

  // Start address of the burst
  always_ff @(posedge CLK)
  begin
    if (addr_phase)
      base_addr <= ad_in;
  end

endmodule

/* hw/pci_target_fsm.sv */
module pci_target_fsm (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              frame_n,
  input  logic                              irdy_n,
  input  pci_bus_pkg::pci_cmd_e             cmd,
  input  logic                              cmd_ok,
  input  logic                              burst_ok,
  input  logic                              ram_hit_n,
  input  logic                              last_word,
  output pci_target_pkg::target_state_e     state,
  output logic                              xfer,
  output logic                              devsel_n,
  output logic                              trdy_n,
  output logic                              stop_n
);
  import pci_bus_pkg::*;
  import pci_target_pkg::*;

  target_state_e next_state;

  //////////////////////////////////////////////////
  // State register

  always_ff @(posedge CLK)
  begin
    if (!RST)
      state <= idle;
    else
      state <= next_state;
  end

  //////////////////////////////////////////////////
  // Next-state logic

  always_comb
  begin
    next_state = state;                               // Hold by default
    case (state)
      idle:
        if (!frame_n)
          next_state = decode;                        // Address phase on the bus
      decode:
        if (frame_n || !cmd_ok)
          next_state = idle;                          // Aborted or not ours
        else
          next_state = claim;
      claim:
        if (ram_hit_n)
          next_state = idle;                          // Master abort, DEVSEL stays high
        else if (!burst_ok)
          next_state = disconnect;                    // Stop without data
        else if (cmd == MEM_WRITE)
          next_state = wr_data;
        else
          next_state = turn_around;
      turn_around:
        next_state = r_data;                          // Single cycle
      wr_data, r_data:
        if (xfer)
        begin
          if (frame_n)
            next_state = terminate;                   // Master's final word
          else if (last_word)
            next_state = disconnect;                  // Budget or RAM end reached
        end
      disconnect:
        if (frame_n)
          next_state = terminate;
      terminate:
        next_state = idle;
      default:
        next_state = idle;
    endcase
  end

  //////////////////////////////////////////////////
  // Bus controls decoded from state

  assign devsel_n = !((state == wr_data) || (state == turn_around) ||
                      (state == r_data)  || (state == disconnect));
  assign trdy_n   = !((state == wr_data) || (state == r_data));
  assign stop_n   = (state != disconnect);

  assign xfer = !trdy_n && !irdy_n;                   // Both sides ready

endmodule

/* hw/pci_data_path.sv */
module pci_data_path (
  input  logic                              CLK,
  input  logic                              RST,
  input  pci_target_pkg::target_state_e     state,
  input  logic                              xfer,
  input  pci_bus_pkg::pci_cmd_e             cmd,
  input  logic [pci_bus_pkg::ADDR_W-1:0]    base_addr,
  inout  wire  [pci_bus_pkg::ADDR_W-1:0]    ad,
  input  logic [pci_bus_pkg::BE_W-1:0]      c_be,
  input  logic                              ram_last,
  input  logic [pci_bus_pkg::ADDR_W-1:0]    ram_rdata,
  output logic                              last_word,
  output logic [pci_bus_pkg::ADDR_W-1:0]    ram_addr,
  output logic [pci_bus_pkg::ADDR_W-1:0]    ram_wdata,
  output logic [pci_bus_pkg::BE_W-1:0]      ram_be,
  output logic                              ram_we
);
  import pci_bus_pkg::*;
  import pci_target_pkg::*;

  logic [BUDGET_W-1:0] budget;                        // Read words left, zero is unbounded
  logic                wr_xfer;
  logic                rd_xfer;

  assign wr_xfer = xfer && (state == wr_data);
  assign rd_xfer = xfer && (state == r_data);

  //////////////////////////////////////////////////
  // Address counter and word budget

  always_ff @(posedge CLK)
  begin
    if (!RST)
      ram_addr <= '0;
    else if (state == decode)
      ram_addr <= base_addr;                          // Loaded on the way to claim
    else if (rd_xfer || ram_we)
      ram_addr <= ram_addr + ADDR_STEP;               // Writes step after their strobe
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
      budget <= '0;
    else if (state == decode)
    begin
      case (cmd)
        MEM_READ:      budget <= READ_BUDGET;
        MEM_READ_LINE: budget <= LINE_BUDGET;
        default:       budget <= '0;                  // Read Multiple and writes
      endcase
    end
    else if (rd_xfer && (budget != '0))
      budget <= budget - 1'b1;
  end

  assign last_word = ram_last || (budget == BUDGET_W'(1));

  //////////////////////////////////////////////////
  // RAM write strobes

  always_ff @(posedge CLK)
  begin
    if (!RST)
      ram_we <= 1'b0;
    else
      ram_we <= wr_xfer;                              // One pulse per accepted word
  end

  always_ff @(posedge CLK)
  begin
    if (wr_xfer)
    begin
      ram_wdata <= ad;
      ram_be    <= c_be;                              // Active low, passed as is
    end
  end

  //////////////////////////////////////////////////
  // AD read drive

  // Enable follows the state register, released on the edge that leaves r_data
  assign ad = (state == r_data) ? ram_rdata : 'z;

endmodule

/* hw/pci_target.sv */
module pci_target (
  input  logic                              CLK,
  input  logic                              RST,
  inout  wire  [pci_bus_pkg::ADDR_W-1:0]    ad,
  input  logic [pci_bus_pkg::BE_W-1:0]      c_be,
  input  logic                              frame_n,
  input  logic                              irdy_n,
  output logic                              trdy_n,
  output logic                              devsel_n,
  output logic                              stop_n,
  input  logic                              ram_hit_n,
  input  logic                              ram_last,
  input  logic [pci_bus_pkg::ADDR_W-1:0]    ram_rdata,
  output logic [pci_bus_pkg::ADDR_W-1:0]    ram_addr,
  output logic [pci_bus_pkg::ADDR_W-1:0]    ram_wdata,
  output logic [pci_bus_pkg::BE_W-1:0]      ram_be,
  output logic                              ram_we
);
  import pci_bus_pkg::*;
  import pci_target_pkg::*;

  pci_cmd_e            cmd;                           // Latched bus command
  logic                cmd_ok;
  logic                burst_ok;
  logic [ADDR_W-1:0]   base_addr;
  target_state_e       state;
  logic                xfer;                          // Data word moves this edge
  logic                last_word;

  pci_cmd_decode u_cmd_decode (
    .CLK       (CLK),
    .RST       (RST),
    .ad_in     (ad),
    .c_be      (c_be),
    .frame_n   (frame_n),
    .state     (state),
    .cmd       (cmd),
    .base_addr (base_addr),
    .cmd_ok    (cmd_ok),
    .burst_ok  (burst_ok)
  );

  pci_target_fsm u_target_fsm (
    .CLK       (CLK),
    .RST       (RST),
    .frame_n   (frame_n),
    .irdy_n    (irdy_n),
    .cmd       (cmd),
    .cmd_ok    (cmd_ok),
    .burst_ok  (burst_ok),
    .ram_hit_n (ram_hit_n),
    .last_word (last_word),
    .state     (state),
    .xfer      (xfer),
    .devsel_n  (devsel_n),
    .trdy_n    (trdy_n),
    .stop_n    (stop_n)
  );

  pci_data_path u_data_path (
    .CLK       (CLK),
    .RST       (RST),
    .state     (state),
    .xfer      (xfer),
    .cmd       (cmd),
    .base_addr (base_addr),
    .ad        (ad),
    .c_be      (c_be),
    .ram_last  (ram_last),
    .ram_rdata (ram_rdata),
    .last_word (last_word),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_be    (ram_be),
    .ram_we    (ram_we)
  );

endmodule

/* testbench/pci_target_chk.sv */
module pci_target_chk (
  input logic CLK,
  input logic RST,
  input logic trdy_n,
  input logic devsel_n,
  input logic stop_n,
  input logic ram_we
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // Bus protocol rules

  trdy_needs_devsel: assert property (@(posedge CLK) disable iff (!RST) !trdy_n |-> !devsel_n)
    else $error("trdy_n low without devsel_n");

  trdy_stop_excl: assert property (@(posedge CLK) disable iff (!RST) !(!trdy_n && !stop_n))
    else $error("trdy_n and stop_n low together");

  we_after_devsel: assert property (@(posedge CLK) disable iff (!RST) ram_we |-> $past(!devsel_n))
    else $error("ram_we without a claimed cycle before it");

  // Second reset edge onward, state is known
  idle_in_reset: assert property (@(posedge CLK) (!RST && $past(!RST)) |->
                                  (trdy_n && devsel_n && stop_n))
    else $error("bus control active during reset");

endmodule

bind pci_target pci_target_chk u_chk (
  .CLK      (CLK),
  .RST      (RST),
  .trdy_n   (trdy_n),
  .devsel_n (devsel_n),
  .stop_n   (stop_n),
  .ram_we   (ram_we)
);

/* testbench/tb_pci_target.sv */
module tb_pci_target;
  timeunit 1ns;
  timeprecision 100ps;
  import pci_bus_pkg::*;

  localparam int MAX_CASES = 32;
  localparam int FIELDS    = 7;                       // Columns per line of the cases file
  localparam logic [31:0] NO_LAST = 32'hFF;

  logic              CLK;
  logic              RST;
  wire  [ADDR_W-1:0] ad;
  logic [ADDR_W-1:0] ad_drv;                          // Master side of AD
  logic              ad_en;
  logic [BE_W-1:0]   c_be;
  logic              frame_n;
  logic              irdy_n;
  logic              trdy_n;
  logic              devsel_n;
  logic              stop_n;
  logic              ram_hit_n;
  logic              ram_last;
  logic [ADDR_W-1:0] ram_rdata;
  logic [ADDR_W-1:0] ram_addr;
  logic [ADDR_W-1:0] ram_wdata;
  logic [BE_W-1:0]   ram_be;
  logic              ram_we;

  logic [31:0] cases_mem [0:MAX_CASES*FIELDS-1];
  logic [31:0] mem [0:255];                           // RAM model, word indexed
  logic [31:0] cur_base;
  logic        cur_hit;
  logic [31:0] cur_last;                              // Word index of ram_last
  integer      seed = 65260;
  int          errors = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  bit          limit_set = 0;

  assign ad        = ad_en ? ad_drv : 'z;
  assign ram_rdata = mem[ram_addr[9:2]];
  assign ram_hit_n = !cur_hit;
  assign ram_last  = (cur_last != NO_LAST) && (((ram_addr - cur_base) >> 2) == cur_last);

  pci_target u_pci_target (.*);

  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;                            // 4 ns period
  end

  always @(posedge CLK)
  begin
    cycle_cnt++;
    if (limit_set && (cycle_cnt > cycle_limit))
    begin
      $display("Run stopped, no progress within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond)
    else
    begin
      $display("%s", what);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Master model, one transaction

  task automatic run_case(input int n, input logic [3:0] cmd, input logic [31:0] base,
                          input int offer, input bit hit, input logic [31:0] last,
                          input int exp_words, input bit exp_stop);
    int          idx;
    int          we_cnt;
    int          wait_cnt;
    int          k;
    int          err0;
    bit          stop_seen;
    bit          devsel_seen;
    bit          done;
    bit          claimed;
    bit          is_wr;
    logic [31:0] wdata [0:15];
    logic [3:0]  be [0:15];
    logic [7:0]  widx;
    err0 = errors;
    cur_base = base;
    cur_hit = hit;
    cur_last = last;
    idx = 0;
    we_cnt = 0;
    stop_seen = 0;
    devsel_seen = 0;
    done = 0;
    is_wr = (cmd == MEM_WRITE);
    claimed = hit && ((cmd == MEM_READ) || (cmd == MEM_WRITE) ||
                      (cmd == MEM_READ_MULT) || (cmd == MEM_READ_LINE));
    @(negedge CLK);
    frame_n = 1'b0;                                   // Address phase
    ad_en = 1'b1;
    ad_drv = base;
    c_be = cmd;
    irdy_n = 1'b1;
    @(negedge CLK);
    ad_en = is_wr;                                    // Reads hand AD over to the target
    c_be = '0;
    wait_cnt = $unsigned($random(seed)) % 3;
    k = 1;
    while (!done)
    begin
      @(negedge CLK);
      k++;
      if (ram_we)
      begin
        widx = base[9:2] + we_cnt;
        check_value("ram_addr", base + ADDR_STEP * we_cnt, ram_addr);
        check_value("ram_wdata", wdata[we_cnt], ram_wdata);
        check_value("ram_be", be[we_cnt], ram_be);
        for (int b = 0; b < BE_W; b++)
          if (!be[we_cnt][b])
            mem[widx][8*b +: 8] = wdata[we_cnt][8*b +: 8]; // Active low byte enable
        we_cnt++;
      end
      if (!devsel_n)
        devsel_seen = 1;
      if ((k >= 3) && devsel_n)
      begin
        done = 1;                                     // Not claimed, or terminated
        if (!is_wr)
          check_value("ad", 'z, ad);                  // Target has let go of AD
        frame_n = 1'b1;
        irdy_n = 1'b1;
        ad_en = 1'b0;
      end
      else if (!stop_n)
      begin
        stop_seen = 1;
        frame_n = 1'b1;                               // Finish after STOP
        irdy_n = 1'b1;
      end
      else if (!trdy_n)
      begin
        if (wait_cnt > 0)
        begin
          irdy_n = 1'b1;                              // Master wait state
          wait_cnt--;
        end
        else
        begin
          irdy_n = 1'b0;
          frame_n = (idx == offer - 1);               // Final offered word
          if (is_wr)
          begin
            wdata[idx] = $random(seed);
            be[idx] = $random(seed);
            ad_drv = wdata[idx];
            c_be = be[idx];
          end
          else
          begin
            widx = base[9:2] + idx;
            check_value("ad", mem[widx], ad);
          end
          idx++;
          wait_cnt = $unsigned($random(seed)) % 3;
        end
      end
      else
        irdy_n = 1'b1;                                // Turn-around
    end
    if (is_wr)
      check_value("ram_we pulses", idx, we_cnt);
    check_value("words moved", exp_words, idx);
    check_value("stop_n low seen", exp_stop, stop_seen);
    check_true(devsel_seen == claimed, "DEVSEL response does not match the claim decision");
    repeat (2) @(negedge CLK);                        // Idle gap
    $display("case %0d cmd %h base %h words %0d stop %0d %s", n, cmd, base, idx, stop_seen,
             (errors == err0) ? "ok" : "FAILED");
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    int n;
    int sum;
    RST = 1'b0;
    frame_n = 1'b1;
    irdy_n = 1'b1;
    c_be = '0;
    ad_en = 1'b0;
    ad_drv = '0;
    cur_base = '0;
    cur_hit = 1'b0;
    cur_last = NO_LAST;
    for (int i = 0; i < 256; i++)
      mem[i] = {16'hC0DE, 8'(~i), 8'(i)};             // Pattern from the word address
    $readmemh("testbench/pci_cases.txt", cases_mem);
    n = 0;
    sum = 4;
    while ((n < MAX_CASES) && !$isunknown(cases_mem[n*FIELDS]))
    begin
      sum += cases_mem[n*FIELDS+2] * 3 + 12;
      n++;
    end
    cycle_limit = sum;
    limit_set = 1;
    repeat (4) @(negedge CLK);
    RST = 1'b1;
    for (int c = 0; c < n; c++)
      run_case(c, cases_mem[c*FIELDS][3:0], cases_mem[c*FIELDS+1], cases_mem[c*FIELDS+2],
               cases_mem[c*FIELDS+3][0], cases_mem[c*FIELDS+4], cases_mem[c*FIELDS+5],
               cases_mem[c*FIELDS+6][0]);
    $display("cases %0d, errors %0d", n, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* testbench/pci_cases.txt */
// cmd base offer hit last_idx(FF none) exp_words exp_stop
// All values hex
7 00000100 4 1 FF 4 0
6 00000100 4 1 FF 2 1
E 00000100 6 1 FF 4 1
C 00000100 3 1 FF 3 0
C 00000100 8 1 2 3 1
7 00000200 5 1 0 1 1
7 00000300 3 0 FF 0 0
0 00000100 2 1 FF 0 0
D 00000100 2 1 FF 0 0
6 00000102 2 1 FF 0 1
6 00000200 1 1 FF 1 0
E 00000104 2 1 FF 2 0
7 00000110 2 1 FF 2 0
C 00000110 2 1 FF 2 0

/* sim.f */
hw/pci_bus_pkg.sv
hw/pci_target_pkg.sv
hw/pci_cmd_decode.sv
hw/pci_target_fsm.sv
hw/pci_data_path.sv
hw/pci_target.sv
testbench/pci_target_chk.sv
testbench/tb_pci_target.sv
